// ==== hw/isaPkg.sv ====
`default_nettype none

package isaPkg;

  // ====================
  // Instruction fields
  // ====================
  localparam int instrWidth = 32;

  localparam int condMsb  = 31;  // Condition field
  localparam int condLsb  = 28;
  localparam int groupMsb = 27;  // Opcode group
  localparam int groupLsb = 26;
  localparam int immBit   = 25;  // DP immediate, or LDR/STR register offset
  localparam int opMsb    = 24;  // DP opcode
  localparam int opLsb    = 21;
  localparam int upBit    = 23;  // Offset added when set
  localparam int byteBit  = 22;
  localparam int sBit     = 20;  // DP flag update
  localparam int loadBit  = 20;  // Same bit as S, load/store only
  localparam int rdMsb    = 15;  // Destination register
  localparam int rdLsb    = 12;

  localparam logic [3:0] pcRegIndex = 4'd15;

  // Opcode groups from bits 27:26
  typedef logic [1:0] groupT;
  localparam groupT groupDataProc  = 2'b00;
  localparam groupT groupLoadStore = 2'b01;
  localparam groupT groupBranch    = 2'b10;
  localparam groupT groupOther     = 2'b11;  // Coprocessor, SWI

  // ====================
  // Condition codes
  // ====================
  typedef logic [3:0] condT;
  localparam condT condEq = 4'b0000;
  localparam condT condNe = 4'b0001;
  localparam condT condCs = 4'b0010;
  localparam condT condCc = 4'b0011;
  localparam condT condMi = 4'b0100;
  localparam condT condPl = 4'b0101;
  localparam condT condVs = 4'b0110;
  localparam condT condVc = 4'b0111;
  localparam condT condHi = 4'b1000;
  localparam condT condLs = 4'b1001;
  localparam condT condGe = 4'b1010;
  localparam condT condLt = 4'b1011;
  localparam condT condGt = 4'b1100;
  localparam condT condLe = 4'b1101;
  localparam condT condAl = 4'b1110;

  // ALU function, same encoding as the DP opcode
  typedef logic [3:0] aluOpT;
  localparam aluOpT aluSub = 4'b0010;
  localparam aluOpT aluAdd = 4'b0100;

endpackage

`default_nettype wire

// ==== hw/pipePkg.sv ====
`default_nettype none

package pipePkg;

  // ====================
  // Flags
  // ====================
  typedef logic [3:0] flagsT;       // {N, Z, C, V}
  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

  typedef logic [1:0] flagWriteT;
  localparam int flagWriteNz = 1;   // Upper half writes N and Z
  localparam int flagWriteCv = 0;   // Lower half writes C and V

  // ====================
  // Memory lanes
  // ====================
  typedef logic [3:0] byteMaskT;    // One enable per byte lane
  typedef logic [1:0] offsetT;      // Byte offset in word
  localparam byteMaskT byteMaskAll  = 4'b1111;
  localparam byteMaskT byteMaskNone = 4'b0000;

  // ====================
  // Datapath selects
  // ====================
  typedef logic [1:0] regSrcT;
  typedef logic [1:0] immSrcT;

  // Main decoder word
  // {regSrc, immSrc, aluSrc, memtoReg, regWrite, memWrite, branch, aluOp}
  localparam int ctrlWidth = 10;

endpackage

`default_nettype wire

// ==== hw/decodeStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
  input  logic [isaPkg::instrWidth-1:0] instrD,
  output pipePkg::regSrcT               regSrcD,
  output pipePkg::immSrcT               immSrcD,
  output logic                          aluSrcD,
  output logic                          memtoRegD,
  output logic                          regWriteD,
  output logic                          memWriteD,
  output logic                          branchD,
  output logic                          pcSrcD,
  output logic                          byteD,
  output isaPkg::aluOpT                 aluControlD,
  output pipePkg::flagWriteT            flagWriteD,
  output isaPkg::condT                  condD
);

  import isaPkg::*;
  import pipePkg::*;

  logic [ctrlWidth-1:0] controlsD;
  groupT                groupD;
  logic                 aluOpD;      // DP instruction, opcode goes to ALU
  logic                 immD;
  logic                 loadD;
  logic                 upD;
  logic                 sD;
  logic [3:0]           rdD;
  logic                 isLoadStoreD;

  // Instruction fields
  assign groupD       = instrD[groupMsb:groupLsb];
  assign immD         = instrD[immBit];
  assign loadD        = instrD[loadBit];
  assign upD          = instrD[upBit];
  assign sD           = instrD[sBit];
  assign rdD          = instrD[rdMsb:rdLsb];
  assign condD        = instrD[condMsb:condLsb];
  assign isLoadStoreD = (groupD == groupLoadStore);

  // ====================
  // Main decoder
  // ====================
  always_comb begin
    case (groupD)
      groupDataProc: begin
        if (immD) controlsD = 10'b00_00_1010_01;  // DP immediate
        else      controlsD = 10'b00_00_0010_01;  // DP register
      end
      groupLoadStore: begin
        // Bit 25 clear means immediate offset here
        if (loadD) begin
          if (immD) controlsD = 10'b00_01_0110_00;  // LDR register offset
          else      controlsD = 10'b00_01_1110_00;  // LDR immediate offset
        end else begin
          if (immD) controlsD = 10'b10_01_0001_00;  // STR register offset
          else      controlsD = 10'b10_01_1001_00;  // STR immediate offset
        end
      end
      groupBranch: controlsD = 10'b01_10_1000_10;  // B
      groupOther:  controlsD = 10'b00_00_0000_00;  // Not supported, acts as NOP
    endcase
  end

  assign {regSrcD, immSrcD, aluSrcD, memtoRegD, regWriteD,
          memWriteD, branchD, aluOpD} = controlsD;

  // ====================
  // ALU decoder
  // ====================
  always_comb begin
    if (isLoadStoreD) begin
      aluControlD = upD ? aluAdd : aluSub;  // Offset direction
      flagWriteD  = 2'b00;
    end else if (aluOpD) begin
      aluControlD = instrD[opMsb:opLsb];   // Opcode straight through
      flagWriteD  = {2{sD}};               // Both halves on S
    end else begin
      aluControlD = aluAdd;                // Branch target add
      flagWriteD  = 2'b00;
    end
  end

  // Byte access only meaningful for LDRB/STRB
  assign byteD = isLoadStoreD & instrD[byteBit];

  // PC written by branch or by any write to r15
  assign pcSrcD = branchD | (regWriteD & (rdD == pcRegIndex));

endmodule

`default_nettype wire

// ==== hw/executeStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module executeStage (
  input  logic               clk,
  input  logic               reset,
  input  logic               flushE,
  // From decode
  input  logic               aluSrcD,
  input  logic               memtoRegD,
  input  logic               regWriteD,
  input  logic               memWriteD,
  input  logic               branchD,
  input  logic               pcSrcD,
  input  logic               byteD,
  input  isaPkg::aluOpT      aluControlD,
  input  pipePkg::flagWriteT flagWriteD,
  input  isaPkg::condT       condD,
  // Flags
  input  pipePkg::flagsT     aluFlagsE,
  input  pipePkg::flagsT     flagsNextM,
  input  pipePkg::flagsT     flagsNextW,
  input  pipePkg::flagsT     committedFlags,
  input  logic               setFlagsM,
  input  logic               setFlagsW,
  // To datapath and memory stage
  output logic               aluSrcE,
  output isaPkg::aluOpT      aluControlE,
  output logic               branchTakenE,
  output logic               regWriteGatedE,
  output logic               memWriteGatedE,
  output logic               pcSrcGatedE,
  output logic               memtoRegE,
  output logic               byteE,
  output logic               setFlagsE,
  output pipePkg::flagsT     flagsNextE,
  output logic               pcWritePending
);

  import isaPkg::*;
  import pipePkg::*;

  logic      regWriteE;
  logic      memWriteE;
  logic      branchE;
  logic      pcSrcE;
  flagWriteT flagWriteE;
  condT      condE;
  flagsT     flagsE;      // Flags as seen by this instruction
  logic      condExE;
  logic      n, z, c, v;

  // ====================
  // D/E register
  // ====================
  always_ff @(posedge clk) begin
    if (reset || flushE) begin  // Bubble on flush
      regWriteE  <= 1'b0;
      memWriteE  <= 1'b0;
      branchE    <= 1'b0;
      pcSrcE     <= 1'b0;
      memtoRegE  <= 1'b0;
      byteE      <= 1'b0;
      flagWriteE <= 2'b00;
    end else begin
      regWriteE  <= regWriteD;
      memWriteE  <= memWriteD;
      branchE    <= branchD;
      pcSrcE     <= pcSrcD;
      memtoRegE  <= memtoRegD;
      byteE      <= byteD;
      flagWriteE <= flagWriteD;
    end
  end

  always_ff @(posedge clk) begin
    condE       <= condD;
    aluSrcE     <= aluSrcD;
    aluControlE <= aluControlD;
  end

  // Youngest pending flags win
  assign flagsE = setFlagsM ? flagsNextM :
                  setFlagsW ? flagsNextW : committedFlags;

  assign n = flagsE[flagN];
  assign z = flagsE[flagZ];
  assign c = flagsE[flagC];
  assign v = flagsE[flagV];

  // ====================
  // Condition check
  // ====================
  always_comb begin
    case (condE)
      condEq:  condExE = z;
      condNe:  condExE = ~z;
      condCs:  condExE = c;
      condCc:  condExE = ~c;
      condMi:  condExE = n;
      condPl:  condExE = ~n;
      condVs:  condExE = v;
      condVc:  condExE = ~v;
      condHi:  condExE = c & ~z;
      condLs:  condExE = ~c | z;
      condGe:  condExE = (n == v);
      condLt:  condExE = (n != v);
      condGt:  condExE = ~z & (n == v);
      condLe:  condExE = z | (n != v);
      condAl:  condExE = 1'b1;
      default: condExE = 1'b1;  // 1111 treated as always
    endcase
  end

  // Writes only when condition passes
  assign branchTakenE   = branchE & condExE;
  assign regWriteGatedE = regWriteE & condExE;
  assign memWriteGatedE = memWriteE & condExE;
  assign pcSrcGatedE    = pcSrcE & condExE;
  assign setFlagsE      = (|flagWriteE) & condExE;

  // Merge ALU flags per half
  assign flagsNextE[flagN:flagZ] = flagWriteE[flagWriteNz] ? aluFlagsE[flagN:flagZ]
                                                           : flagsE[flagN:flagZ];
  assign flagsNextE[flagC:flagV] = flagWriteE[flagWriteCv] ? aluFlagsE[flagC:flagV]
                                                           : flagsE[flagC:flagV];

  assign pcWritePending = pcSrcD | pcSrcE;  // M term added at top

endmodule

`default_nettype wire

// ==== hw/memoryStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module memoryStage (
  input  logic              clk,
  input  logic              reset,
  input  logic              regWriteGatedE,
  input  logic              memWriteGatedE,
  input  logic              pcSrcGatedE,
  input  logic              memtoRegE,
  input  logic              byteE,
  input  logic              setFlagsE,
  input  pipePkg::flagsT    flagsNextE,
  input  pipePkg::offsetT   aluResultE,
  output logic              memWriteM,
  output pipePkg::byteMaskT byteMaskM,
  output logic              regWriteM,
  output logic              memtoRegM,
  output logic              pcSrcM,
  output logic              setFlagsM,
  output pipePkg::flagsT    flagsNextM
);

  import pipePkg::*;

  logic   byteM;
  offsetT offsetM;

  always_ff @(posedge clk) begin
    if (reset) begin
      memWriteM <= 1'b0;
      regWriteM <= 1'b0;
      memtoRegM <= 1'b0;
      pcSrcM    <= 1'b0;
      setFlagsM <= 1'b0;
      byteM     <= 1'b0;
    end else begin
      memWriteM <= memWriteGatedE;
      regWriteM <= regWriteGatedE;
      memtoRegM <= memtoRegE;
      pcSrcM    <= pcSrcGatedE;
      setFlagsM <= setFlagsE;
      byteM     <= byteE;
    end
  end

  always_ff @(posedge clk) begin
    offsetM    <= aluResultE;
    flagsNextM <= flagsNextE;
  end

  // Lane enables, little-endian
  always_comb begin
    if (!memWriteM)  byteMaskM = byteMaskNone;  // Loads and others
    else if (!byteM) byteMaskM = byteMaskAll;   // Word store
    else             byteMaskM = byteMaskT'(4'b0001 << offsetM);
  end

endmodule

`default_nettype wire

// ==== hw/writebackStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module writebackStage (
  input  logic           clk,
  input  logic           reset,
  input  logic           regWriteM,
  input  logic           memtoRegM,
  input  logic           pcSrcM,
  input  logic           setFlagsM,
  input  pipePkg::flagsT flagsNextM,
  output logic           regWriteW,
  output logic           memtoRegW,
  output logic           pcSrcW,
  output logic           setFlagsW,
  output pipePkg::flagsT flagsNextW,
  output pipePkg::flagsT committedFlags
);

  import pipePkg::*;

  // ====================
  // M/W register
  // ====================
  always_ff @(posedge clk) begin
    if (reset) begin
      regWriteW <= 1'b0;
      memtoRegW <= 1'b0;
      pcSrcW    <= 1'b0;
      setFlagsW <= 1'b0;
    end else begin
      regWriteW <= regWriteM;
      memtoRegW <= memtoRegM;
      pcSrcW    <= pcSrcM;
      setFlagsW <= setFlagsM;
    end
  end

  always_ff @(posedge clk) begin
    flagsNextW <= flagsNextM;  // Qualified by setFlagsW
  end

  // ====================
  // Flags register
  // ====================
  always_ff @(posedge clk) begin
    if (reset) begin
      committedFlags <= flagsT'(4'b0000);
    end else if (setFlagsW) begin
      committedFlags <= flagsNextW;  // Commit one cycle after W
    end
  end

endmodule

`default_nettype wire

// ==== hw/armController.sv ====
`timescale 1ns/10ps
`default_nettype none

module armController (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [isaPkg::instrWidth-1:0] instrD,
  input  pipePkg::flagsT                aluFlagsE,
  input  pipePkg::offsetT               aluResultE,
  input  logic                          flushE,
  // Datapath selects
  output pipePkg::regSrcT               regSrcD,
  output pipePkg::immSrcT               immSrcD,
  output logic                          aluSrcE,
  output isaPkg::aluOpT                 aluControlE,
  // Gated controls
  output logic                          branchTakenE,
  output logic                          memWriteM,
  output pipePkg::byteMaskT             byteMaskM,
  output logic                          regWriteW,
  output logic                          memtoRegW,
  output logic                          pcSrcW,
  output logic                          pcWritePending,
  output pipePkg::flagsT                committedFlags
);

  import isaPkg::*;
  import pipePkg::*;

  logic      aluSrcD, memtoRegD, regWriteD, memWriteD;
  logic      branchD, pcSrcD, byteD;
  aluOpT     aluControlD;
  flagWriteT flagWriteD;
  condT      condD;
  logic      regWriteGatedE, memWriteGatedE, pcSrcGatedE;
  logic      memtoRegE, byteE, setFlagsE, pcWritePendingDE;
  logic      regWriteM, memtoRegM, pcSrcM, setFlagsM, setFlagsW;
  flagsT     flagsNextE, flagsNextM, flagsNextW;

  decodeStage decode (
    .instrD, .regSrcD, .immSrcD, .aluSrcD, .memtoRegD, .regWriteD, .memWriteD,
    .branchD, .pcSrcD, .byteD, .aluControlD, .flagWriteD, .condD
  );

  executeStage execute (
    .clk, .reset, .flushE,
    .aluSrcD, .memtoRegD, .regWriteD, .memWriteD, .branchD, .pcSrcD, .byteD,
    .aluControlD, .flagWriteD, .condD,
    .aluFlagsE, .flagsNextM, .flagsNextW, .committedFlags, .setFlagsM, .setFlagsW,
    .aluSrcE, .aluControlE, .branchTakenE, .regWriteGatedE, .memWriteGatedE,
    .pcSrcGatedE, .memtoRegE, .byteE, .setFlagsE, .flagsNextE,
    .pcWritePending(pcWritePendingDE)
  );

  memoryStage memory (
    .clk, .reset, .regWriteGatedE, .memWriteGatedE, .pcSrcGatedE, .memtoRegE,
    .byteE, .setFlagsE, .flagsNextE, .aluResultE,
    .memWriteM, .byteMaskM, .regWriteM, .memtoRegM, .pcSrcM, .setFlagsM, .flagsNextM
  );

  writebackStage writeback (
    .clk, .reset, .regWriteM, .memtoRegM, .pcSrcM, .setFlagsM, .flagsNextM,
    .regWriteW, .memtoRegW, .pcSrcW, .setFlagsW, .flagsNextW, .committedFlags
  );

  // PC write anywhere in D, E or M holds fetch
  assign pcWritePending = pcWritePendingDE | pcSrcM;

endmodule

`default_nettype wire

// ==== bench/controllerChecker.sv ====
`timescale 1ns/10ps
`default_nettype none

module controllerChecker (
  input  logic                          clk,
  input  logic                          expValid,      // A line was issued this cycle
  input  logic [23:0]                   expLine,       // Expected fields of that line
  input  logic [isaPkg::instrWidth-1:0] instrD,        // Instruction driven with the line
  input  logic                          flushE,        // Flush driven with the line
  input  pipePkg::regSrcT               regSrcD,
  input  pipePkg::immSrcT               immSrcD,
  input  logic                          aluSrcE,
  input  isaPkg::aluOpT                 aluControlE,
  input  logic                          branchTakenE,
  input  logic                          memWriteM,
  input  pipePkg::byteMaskT             byteMaskM,
  input  logic                          regWriteW,
  input  logic                          memtoRegW,
  input  logic                          pcSrcW,
  input  logic                          pcWritePending,
  input  pipePkg::flagsT                committedFlags,
  output int                            checkCount,
  output int                            errorCount
);

  import isaPkg::*;
  import pipePkg::*;

  int          checks = 0;
  int          errors = 0;
  logic [4:0]  validPipe = '0;   // Bit i set for the line issued i cycles ago
  logic [4:0]  flushPipe = '0;
  logic [23:0] linePipe [0:4];
  logic [31:0] instrPipe [0:4];

  assign checkCount = checks;
  assign errorCount = errors;

  task automatic compareField(input string what, input logic [3:0] got,
                              input logic [3:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERR %0t: %s got %h, expected %h", $time, what, got, want);
    end
  endtask

  // Datapath selects by class, {regSrc, immSrc, aluSrc, aluOp}
  function automatic logic [8:0] decodeSelects(input logic [31:0] instr);
    logic [3:0] offsetOp;
    offsetOp = instr[upBit] ? aluAdd : aluSub;
    case (instr[groupMsb:groupLsb])
      groupDataProc:  return {2'b00, 2'b00, instr[immBit], instr[opMsb:opLsb]};
      groupLoadStore: return {(instr[loadBit] ? 2'b00 : 2'b10), 2'b01, ~instr[immBit], offsetOp};
      groupBranch:    return {2'b01, 2'b10, 1'b1, aluAdd};  // Reads PC, 24-bit offset
      default:        return {2'b00, 2'b00, 1'b0, aluAdd};
    endcase
  endfunction

  // Branch, or a register write aimed at r15
  function automatic logic writesPc(input logic [31:0] instr);
    logic writesReg;
    writesReg = (instr[groupMsb:groupLsb] == groupDataProc) ||
                (instr[groupMsb:groupLsb] == groupLoadStore && instr[loadBit]);
    return (instr[groupMsb:groupLsb] == groupBranch) ||
           (writesReg && instr[rdMsb:rdLsb] == pcRegIndex);
  endfunction

  function automatic logic loadsMemory(input logic [31:0] instr);
    return instr[groupMsb:groupLsb] == groupLoadStore && instr[loadBit];
  endfunction

  // ====================
  // Pipeline model
  // ====================
  // Negedge sampling, all outputs settled by then
  always @(negedge clk) begin : trackAndCompare
    int         stage;
    logic [8:0] selects;
    logic       pending;
    validPipe = {validPipe[3:0], expValid};
    flushPipe = {flushPipe[3:0], flushE};
    for (stage = 4; stage > 0; stage--) begin
      linePipe[stage]  = linePipe[stage-1];
      instrPipe[stage] = instrPipe[stage-1];
    end
    linePipe[0]  = expLine;
    instrPipe[0] = instrD;
    if (validPipe[0]) begin  // Decode, selects straight from instrD
      selects = decodeSelects(instrPipe[0]);
      compareField("regSrcD", {2'b00, regSrcD}, {2'b00, selects[8:7]});
      compareField("immSrcD", {2'b00, immSrcD}, {2'b00, selects[6:5]});
    end
    if (validPipe[1]) begin  // Execute window
      compareField("branchTakenE", {3'b000, branchTakenE}, {3'b000, linePipe[1][20]});
      if (!flushPipe[1]) begin  // Bubble selects are don't care
        selects = decodeSelects(instrPipe[1]);
        compareField("aluSrcE", {3'b000, aluSrcE}, {3'b000, selects[4]});
        compareField("aluControlE", aluControlE, selects[3:0]);
      end
    end
    if (validPipe[2]) begin  // Memory stage
      compareField("memWriteM", {3'b000, memWriteM}, {3'b000, linePipe[2][16]});
      compareField("byteMaskM", byteMaskM, linePipe[2][15:12]);
    end
    if (validPipe[3]) begin  // Writeback stage
      compareField("regWriteW", {3'b000, regWriteW}, {3'b000, linePipe[3][8]});
      compareField("pcSrcW", {3'b000, pcSrcW}, {3'b000, linePipe[3][4]});
      compareField("memtoRegW", {3'b000, memtoRegW},
                   {3'b000, loadsMemory(instrPipe[3]) & ~flushPipe[3]});
    end
    if (|validPipe[2:0]) begin
      // Raw PC write in D, unflushed one in E, condition-passed one in M
      pending = (validPipe[0] && writesPc(instrPipe[0])) ||
                (validPipe[1] && writesPc(instrPipe[1]) && !flushPipe[1]) ||
                (validPipe[2] && linePipe[2][4]);
      compareField("pcWritePending", {3'b000, pcWritePending}, {3'b000, pending});
    end
    if (validPipe[4]) begin
      compareField("committedFlags", committedFlags, linePipe[4][3:0]);  // After commit edge
    end
  end

endmodule

`default_nettype wire

// ==== bench/controller_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module controllerSva (
  input logic clk,
  input logic reset,
  input logic flushE,
  input logic branchTakenE,
  input logic memWriteM,
  input logic regWriteW,
  input logic pcSrcW
);

  // Every write and branch strobe low one edge into reset
  resetQuiet: assert property (@(posedge clk)
    $past(reset) |-> !(branchTakenE || memWriteM || regWriteW || pcSrcW))
    else $error("Write or branch output high during reset");

  // Bubble from a flush reaches the memory stage two edges later
  flushBubble: assert property (@(posedge clk) disable iff (reset)
    $past(flushE, 2) |-> !memWriteM)
    else $error("Flushed instruction still wrote memory");

  // Same bubble in writeback, no register or PC write
  flushNoRegWrite: assert property (@(posedge clk) disable iff (reset)
    $past(flushE, 3) |-> !(regWriteW || pcSrcW))
    else $error("Flushed instruction still wrote a register");

endmodule

bind armController controllerSva sva (
  .clk, .reset, .flushE, .branchTakenE, .memWriteM, .regWriteW, .pcSrcW
);

`default_nettype wire

// ==== bench/controllerTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module controllerTb;

  import isaPkg::*;
  import pipePkg::*;

  localparam int maxLines  = 64;
  localparam int clkPeriod = 40;
  localparam logic [instrWidth-1:0] nopInstr = 32'hEC00_0000;  // Group 11, no controls

  // instr | aluFlags | offset | flush | branch | memWrite | mask | regWrite | pcSrc | flags
  logic [67:0] vectors [0:maxLines-1];

  logic                  clk        = 1'b0;
  logic                  reset      = 1'b1;
  logic [instrWidth-1:0] instrD     = nopInstr;
  flagsT                 aluFlagsE  = 4'h0;
  offsetT                aluResultE = 2'b00;
  logic                  flushE     = 1'b0;
  logic                  expValid   = 1'b0;
  logic [23:0]           expLine    = '0;
  regSrcT                regSrcD;
  immSrcT                immSrcD;
  logic                  aluSrcE, branchTakenE, memWriteM, regWriteW, memtoRegW, pcSrcW;
  logic                  pcWritePending;
  aluOpT                 aluControlE;
  byteMaskT              byteMaskM;
  flagsT                 committedFlags;
  int                    lineCount = 0;
  logic                  lineCountKnown = 1'b0;
  int                    checkCount, errorCount;
  logic [31:0]           lfsrState = 32'hb9b9;

  armController uut (.*);

  controllerChecker outputCheck (
    .clk, .expValid, .expLine, .instrD, .flushE, .regSrcD, .immSrcD, .aluSrcE,
    .aluControlE, .branchTakenE, .memWriteM, .byteMaskM, .regWriteW, .memtoRegW,
    .pcSrcW, .pcWritePending, .committedFlags, .checkCount, .errorCount
  );

  always #(clkPeriod / 2) clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic takeRandomBits(input int count, output logic [31:0] bits);
    bits = '0;
    repeat (count) begin
      lfsrState = lfsrNext(lfsrState);  // One step per bit
      bits = {bits[30:0], lfsrState[0]};
    end
  endtask

  // Live writes sitting in decode while reset is high
  function automatic logic [instrWidth-1:0] resetStimulus(input int cycle);
    case (cycle % 3)
      0:       return 32'hE505_2004;  // STR r2, [r5, #-4]
      1:       return 32'hEA00_0000;  // B
      default: return 32'hE1A0_F00E;  // MOV pc, r14
    endcase
  endfunction

  // ====================
  // Stimulus
  // ====================
  initial begin : stimulus
    logic [67:0] vec;
    logic [31:0] instr;
    logic [31:0] rnd;
    flagsT       nextFlags;
    offsetT      nextOffset;
    int          idx;
    $readmemh("bench/controllerInput.dat", vectors);
    while (lineCount < maxLines && vectors[lineCount][67:36] !== 32'hFFFF_FFFF) begin
      lineCount++;  // Stop at end marker
    end
    lineCountKnown = 1'b1;
    nextFlags  = '0;
    nextOffset = '0;
    for (idx = 0; idx < 8; idx++) begin
      instrD <= resetStimulus(idx);
      @(posedge clk);
    end
    reset <= 1'b0;
    for (idx = 0; idx < lineCount; idx++) begin
      vec   = vectors[idx];
      instr = vec[67:36];
      if (instr[groupMsb:groupLsb] == groupOther) begin  // Filler line
        takeRandomBits(30, rnd);
        instr = {rnd[29:26], groupOther, rnd[25:0]};
      end
      instrD     <= instr;
      flushE     <= vec[24];      // Sampled as the line enters execute
      aluFlagsE  <= nextFlags;    // ALU side lags one cycle
      aluResultE <= nextOffset;
      expValid   <= 1'b1;
      expLine    <= vec[23:0];
      nextFlags  = vec[35:32];
      nextOffset = vec[29:28];
      @(posedge clk);
    end
    instrD     <= nopInstr;
    flushE     <= 1'b0;
    aluFlagsE  <= nextFlags;
    aluResultE <= nextOffset;
    expValid   <= 1'b0;
    repeat (6) @(posedge clk);  // Drain to flag commit
    $display("Lines: %0d, checks: %0d, errors: %0d", lineCount, checkCount, errorCount);
    if (checkCount == 0) begin
      $display("No checks ran, stimulus file empty or unreadable");
    end
    if (errorCount == 0 && checkCount > 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    wait (lineCountKnown);
    #((lineCount + 20) * clkPeriod);
    $display("Watchdog timeout: simulation did not finish in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/controllerInput.dat ====
// instr_aluFlags_offset_flush_expBranch_expMemWrite_expMask_expRegWrite_expPcSrc_expFlags
// Flags nibble is {N,Z,C,V}; group 11 lines are filler; all-F line ends the list
E2521001_4_0_0_0_0_0_1_0_4  // SUBS r1, r2, #1
00833004_f_0_0_0_0_0_1_0_4  // ADDEQ r3, r3, r4
1A000004_0_0_0_0_0_0_0_0_4  // BNE
0A000002_0_0_0_1_0_0_0_1_4  // BEQ
EC000000_0_0_0_0_0_0_0_0_4  // filler
E5C52003_0_3_0_0_1_8_0_0_4  // STRB r2, [r5, #3]
E5052004_0_1_0_0_1_f_0_0_4  // STR r2, [r5, #-4]
E5D56001_0_2_0_0_0_0_1_0_4  // LDRB r6, [r5, #1]
15C52002_0_2_0_0_0_0_0_0_4  // STRBNE r2, [r5, #2]
E2977001_8_0_1_0_0_0_0_0_4  // ADDS r7, r7, #1 flushed
E3988000_9_0_0_0_0_0_1_0_9  // ORRS r8, r8, #0
A3A09005_0_0_0_0_0_0_1_0_9  // MOVGE r9, #5
B3A0F040_0_0_0_0_0_0_0_0_9  // MOVLT pc, #0x40
E1A0F00E_0_0_0_0_0_0_1_1_9  // MOV pc, r14
E0511001_6_0_0_0_0_0_1_0_6  // SUBS r1, r1, r1
8A000010_0_0_0_0_0_0_0_0_6  // BHI
9A000010_0_0_0_1_0_0_0_1_6  // BLS
E2822004_f_0_0_0_0_0_1_0_6  // ADD r2, r2, #4
EC000000_0_0_0_0_0_0_0_0_6  // filler
FFFFFFFF_f_f_f_f_f_f_f_f_f  // end marker

// ==== verilog.f ====
hw/isaPkg.sv
hw/pipePkg.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/writebackStage.sv
hw/armController.sv
bench/controllerChecker.sv
bench/controller_sva.sv
bench/controllerTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module controllerTb -f verilog.f || exit 1
simOut="$(./obj_dir/VcontrollerTb)"
echo "$simOut"
echo "$simOut" | grep -qx "TEST RESULT: PASS" && echo "Simulation passed" || exit 1
